//--- Bender.yml
package:
  name: led_matrix

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/led_matrix_pkg.sv
      - rtl/uart_rx.sv
      - rtl/command_decoder.sv
      - rtl/framebuffer_ram.sv
      - rtl/framebuffer_fetch.sv
      - rtl/matrix_scan.sv
      - rtl/pixel_split.sv
      - rtl/led_matrix_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_led_matrix.sv

//--- project.f
+incdir+rtl
rtl/led_matrix_pkg.sv
rtl/uart_rx.sv
rtl/command_decoder.sv
rtl/framebuffer_ram.sv
rtl/framebuffer_fetch.sv
rtl/matrix_scan.sv
rtl/pixel_split.sv
rtl/led_matrix_top.sv
test/tb_led_matrix.sv

//--- rtl/command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_cfg.svh"

module command_decoder import led_matrix_pkg::*; (
    input  wire logic       clk_root,
    input  wire logic       rst_n,
    input  wire logic [7:0] rx_byte,
    input  wire logic       rx_strobe,
    output fb_write_t       fb_write,
    output display_ctrl_t   display_ctrl
);

    typedef enum logic [1:0] {CD_IDLE, CD_PIXEL, CD_COLOUR, CD_MASK} cd_state_t;

    cd_state_t state;
    logic [1:0] byte_cnt; // operand index within CMD_PIXEL
    logic wr_strobe;
    col_t wr_x;
    logic [$clog2(`LM_PIXEL_HEIGHT)-1:0] wr_y;
    logic [7:0] hi_q;
    rgb565_t wr_pixel;
    display_ctrl_t ctrl_q;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state <= CD_IDLE;
            byte_cnt <= '0;
            wr_strobe <= 1'b0;
            ctrl_q <= '1; // everything on after reset
        end else begin
            wr_strobe <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    CD_IDLE: begin
                        byte_cnt <= '0;
                        case (rx_byte)
                            CMD_PIXEL: state <= CD_PIXEL;
                            CMD_COLOUR: state <= CD_COLOUR;
                            CMD_MASK: state <= CD_MASK;
                            default: state <= CD_IDLE; // stray byte
                        endcase
                    end
                    CD_PIXEL: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin // low byte
                            wr_strobe <= 1'b1;
                            state <= CD_IDLE;
                        end
                    end
                    CD_COLOUR: begin
                        ctrl_q.rgb_enable <= rx_byte[2:0];
                        state <= CD_IDLE;
                    end
                    default: begin
                        ctrl_q.brightness_enable <= rx_byte[`LM_PLANES-1:0];
                        state <= CD_IDLE;
                    end
                endcase
            end
        end
    end

    // operand capture
    always_ff @(posedge clk_root) begin
        if (rx_strobe && state == CD_PIXEL) begin
            case (byte_cnt)
                2'd0: wr_x <= rx_byte[$bits(col_t)-1:0];
                2'd1: wr_y <= rx_byte[$bits(wr_y)-1:0];
                2'd2: hi_q <= rx_byte;
                default: wr_pixel <= {hi_q, rx_byte};
            endcase
        end
    end

    assign fb_write = '{strobe: wr_strobe, x: wr_x, y: wr_y, pixel: wr_pixel};
    assign display_ctrl = ctrl_q;

endmodule

`default_nettype wire

//--- rtl/framebuffer_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module framebuffer_fetch import led_matrix_pkg::*; (
    input  wire logic        clk_root,
    input  wire logic        rst_n,
    input  wire logic        fetch_strobe,
    input  wire col_t        fetch_col,
    input  wire row_t        row,
    output col_t             rd_col,
    output row_t             rd_row,
    input  wire pixel_pair_t rd_pair,
    output pixel_pair_t      pair
);

    logic req_valid;  // address sits at the RAM
    logic data_valid; // RAM output holds the requested pair

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            req_valid <= fetch_strobe;
            data_valid <= req_valid;
        end
    end

    // pair holds between fetches so the splitters see steady data
    always_ff @(posedge clk_root) begin
        if (fetch_strobe) begin
            rd_col <= fetch_col;
            rd_row <= row;
        end
        if (data_valid) pair <= rd_pair;
    end

endmodule

`default_nettype wire

//--- rtl/framebuffer_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_cfg.svh"

module framebuffer_ram import led_matrix_pkg::*; (
    input  wire logic      clk_root,
    input  wire fb_write_t fb_write,
    input  wire col_t      rd_col,
    input  wire row_t      rd_row,
    output pixel_pair_t    rd_pair
);

    localparam int DEPTH = `LM_PIXEL_WIDTH * `LM_PIXEL_HALFHEIGHT;
    localparam int AW = $clog2(DEPTH);

    rgb565_t bank_top [DEPTH]; // rows 0..3
    rgb565_t bank_bot [DEPTH]; // rows 4..7
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;
    logic wr_bank;

    assign wr_addr = {row_t'(fb_write.y), fb_write.x};
    assign wr_bank = fb_write.y[$bits(fb_write.y)-1];
    assign rd_addr = {rd_row, rd_col};

    always_ff @(posedge clk_root) begin
        if (fb_write.strobe && !wr_bank) bank_top[wr_addr] <= fb_write.pixel;
        if (fb_write.strobe && wr_bank) bank_bot[wr_addr] <= fb_write.pixel;
        rd_pair <= '{top: bank_top[rd_addr], bottom: bank_bot[rd_addr]};
    end

endmodule

`default_nettype wire

//--- rtl/led_matrix_cfg.svh
`ifndef LED_MATRIX_CFG_SVH
`define LED_MATRIX_CFG_SVH

// panel geometry
`define LM_PIXEL_WIDTH 16
`define LM_PIXEL_HEIGHT 8
`define LM_PIXEL_HALFHEIGHT 4 // rows per half, top and bottom share a scan row

// six bitplanes give RGB666 depth after red/blue widening
`define LM_PLANES 6

// serial command port
`define LM_CLKS_PER_BIT 8 // system clocks per 8N1 bit

// display timing
// plane p stays lit for LM_ON_BASE << p cycles
`define LM_ON_BASE 4

`endif

//--- rtl/led_matrix_pkg.sv
`default_nettype none

package led_matrix_pkg;

`include "led_matrix_cfg.svh"

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // one read returns both halves of the panel
    typedef struct packed {
        rgb565_t top;
        rgb565_t bottom;
    } pixel_pair_t;

    typedef logic [$clog2(`LM_PIXEL_WIDTH)-1:0] col_t;
    typedef logic [$clog2(`LM_PIXEL_HALFHEIGHT)-1:0] row_t;
    typedef logic [$clog2(`LM_PLANES)-1:0] plane_t;

    typedef struct packed {
        logic strobe;
        col_t x;
        logic [$clog2(`LM_PIXEL_HEIGHT)-1:0] y; // msb picks the half
        rgb565_t pixel;
    } fb_write_t;

    typedef struct packed {
        logic [2:0] rgb_enable; // bit 0 red, 1 green, 2 blue
        logic [`LM_PLANES-1:0] brightness_enable;
    } display_ctrl_t;

    typedef struct packed {
        logic [2:0] rgb1; // top half
        logic [2:0] rgb2; // bottom half
        row_t row;
        logic clk_pixel;
        logic latch;
        logic oe_n;
    } hub75_t;

    localparam logic [7:0] CMD_PIXEL = 8'h50;  // "P"
    localparam logic [7:0] CMD_COLOUR = 8'h43; // "C"
    localparam logic [7:0] CMD_MASK = 8'h4D;   // "M"

endpackage

`default_nettype wire

//--- rtl/led_matrix_top.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix_top import led_matrix_pkg::*; (
    input  wire logic clk_root,
    input  wire logic rst_n,
    input  wire logic serial_in,
    output hub75_t    panel
);

    logic [7:0] rx_byte;
    logic rx_strobe;
    fb_write_t fb_write;
    display_ctrl_t display_ctrl;
    logic fetch_strobe;
    col_t fetch_col;
    row_t row;
    plane_t plane;
    col_t rd_col;
    row_t rd_row;
    pixel_pair_t rd_pair;
    pixel_pair_t pair;
    logic clk_pixel;
    logic latch;
    logic oe_n;
    logic [2:0] rgb_top;
    logic [2:0] rgb_bottom;

    uart_rx ctrl_uart (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .serial_in(serial_in),
        .rx_byte(rx_byte),
        .rx_strobe(rx_strobe)
    );

    command_decoder ctrl (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .rx_byte(rx_byte),
        .rx_strobe(rx_strobe),
        .fb_write(fb_write),
        .display_ctrl(display_ctrl)
    );

    framebuffer_ram fb (
        .clk_root(clk_root),
        .fb_write(fb_write),
        .rd_col(rd_col),
        .rd_row(rd_row),
        .rd_pair(rd_pair)
    );

    framebuffer_fetch fb_f (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .fetch_strobe(fetch_strobe),
        .fetch_col(fetch_col),
        .row(row),
        .rd_col(rd_col),
        .rd_row(rd_row),
        .rd_pair(rd_pair),
        .pair(pair)
    );

    matrix_scan matscan (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .fetch_strobe(fetch_strobe),
        .fetch_col(fetch_col),
        .row(row),
        .plane(plane),
        .clk_pixel(clk_pixel),
        .latch(latch),
        .oe_n(oe_n)
    );

    pixel_split px_top (
        .pixel(pair.top),
        .plane(plane),
        .display_ctrl(display_ctrl),
        .rgb(rgb_top)
    );

    pixel_split px_bottom (
        .pixel(pair.bottom),
        .plane(plane),
        .display_ctrl(display_ctrl),
        .rgb(rgb_bottom)
    );

    assign panel = '{
        rgb1: rgb_top,
        rgb2: rgb_bottom,
        row: row, // row being shifted is the row shown after latch
        clk_pixel: clk_pixel,
        latch: latch,
        oe_n: oe_n
    };

endmodule

`default_nettype wire

//--- rtl/matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_cfg.svh"

module matrix_scan import led_matrix_pkg::*; (
    input  wire logic clk_root,
    input  wire logic rst_n,
    output logic      fetch_strobe,
    output col_t      fetch_col,
    output row_t      row,
    output plane_t    plane,
    output logic      clk_pixel,
    output logic      latch,
    output logic      oe_n
);

    // fetch to pair takes three edges, plus one cycle of settled data
    localparam int PIPE_STEPS = 4;
    localparam int FETCH_STEPS = 2 * `LM_PIXEL_WIDTH;
    localparam int LAST_STEP = 2 * (`LM_PIXEL_WIDTH - 1) + PIPE_STEPS;
    localparam int STEP_W = $clog2(LAST_STEP + 1);
    localparam int ON_W = $clog2((`LM_ON_BASE << (`LM_PLANES - 1)) + 1);

    typedef enum logic [1:0] {SC_SHIFT, SC_LATCH, SC_DISPLAY} scan_state_t;

    scan_state_t state;
    logic [STEP_W-1:0] step; // half-rate column sequencer
    logic [ON_W-1:0] on_cnt;
    logic [ON_W-1:0] on_len;

    assign on_len = ON_W'(`LM_ON_BASE) << plane;

    // even steps feed the pipeline, clk_pixel trails by PIPE_STEPS
    assign fetch_strobe = (state == SC_SHIFT) && !step[0]
                          && (step < STEP_W'(FETCH_STEPS));
    assign fetch_col = col_t'(step >> 1);
    assign clk_pixel = (state == SC_SHIFT) && !step[0]
                       && (step >= STEP_W'(PIPE_STEPS));
    assign latch = (state == SC_LATCH);
    assign oe_n = (state != SC_DISPLAY);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state <= SC_SHIFT;
            step <= '0;
            on_cnt <= '0;
            plane <= '0;
            row <= '0;
        end else begin
            case (state)
                SC_SHIFT: begin
                    if (step == STEP_W'(LAST_STEP)) begin // 16th clk_pixel
                        step <= '0;
                        state <= SC_LATCH;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                SC_LATCH: begin
                    on_cnt <= on_len - 1'b1;
                    state <= SC_DISPLAY;
                end
                default: begin
                    if (on_cnt == '0) begin
                        state <= SC_SHIFT;
                        if (plane == plane_t'(`LM_PLANES - 1)) begin
                            plane <= '0;
                            // next scan row once all planes are shown
                            if (row == row_t'(`LM_PIXEL_HALFHEIGHT - 1)) begin
                                row <= '0;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        on_cnt <= on_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/pixel_split.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_split import led_matrix_pkg::*; (
    input  wire rgb565_t       pixel,
    input  wire plane_t        plane,
    input  wire display_ctrl_t display_ctrl,
    output logic [2:0]         rgb
);

    logic [$bits(pixel.g)-1:0] red6;
    logic [$bits(pixel.g)-1:0] blue6;
    logic plane_on;

    // 5-bit channels reuse their msb as the extra low bit
    assign red6 = {pixel.r, pixel.r[4]};
    assign blue6 = {pixel.b, pixel.b[4]};

    assign plane_on = display_ctrl.brightness_enable[plane];

    assign rgb[0] = red6[plane] & plane_on & display_ctrl.rgb_enable[0];
    assign rgb[1] = pixel.g[plane] & plane_on & display_ctrl.rgb_enable[1];
    assign rgb[2] = blue6[plane] & plane_on & display_ctrl.rgb_enable[2];

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_cfg.svh"

module uart_rx (
    input  wire logic clk_root,
    input  wire logic rst_n,
    input  wire logic serial_in,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);

    localparam int CNT_W = $clog2(`LM_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`LM_CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`LM_CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t state;
    logic [1:0] sync_q;
    logic rx_in;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0] bit_cnt;

    // line idles high, so the synchronizer resets to ones
    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], serial_in};
        end
    end

    assign rx_in = sync_q[1];

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state <= RX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_in) state <= RX_START;
                end
                RX_START: begin
                    if (clk_cnt == HALF_BIT) begin // middle of start bit
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state <= rx_in ? RX_IDLE : RX_DATA; // drop glitches
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == FULL_BIT) begin
                        state <= RX_IDLE;
                        rx_strobe <= rx_in; // framing error gives no strobe
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_root) begin
        if (state == RX_DATA && clk_cnt == FULL_BIT) begin
            rx_byte <= {rx_in, rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- test/led_patterns.txt
# P x y rgb565_hex | C rgb_enable_hex | M plane_enable_hex | R random fill | F check frame
# S row plane col top bottom (decimal bits) | B bad_stop_byte_hex next_byte_hex
R
F
C 2
F
C 7
P 0 0 FFFF
P 0 4 F800
P 5 2 07E0
P 5 6 001F
P 9 1 8000
P 9 5 0010
M 36
F
S 0 0 0 0 0
S 0 1 0 7 1
S 0 3 0 0 0
S 0 5 0 7 1
S 2 2 5 2 4
S 2 3 5 0 0
S 1 5 9 1 4
S 1 1 9 0 0
B 43 00
F

//--- test/tb_led_matrix.sv
`timescale 1ns/1ps
`default_nettype none

`include "led_matrix_cfg.svh"

module tb_led_matrix import led_matrix_pkg::*; ();

    localparam int HALF = `LM_PIXEL_HALFHEIGHT;
    localparam int FRAME_TIMEOUT = 8000; // cycles, one frame takes under 2000

    logic clk_root;
    logic rst_n;
    logic serial_in;
    hub75_t panel;

    rgb565_t model_fb [`LM_PIXEL_HEIGHT][`LM_PIXEL_WIDTH];
    display_ctrl_t model_ctrl;
    logic [2:0] line_top [`LM_PIXEL_WIDTH]; // samples of the row being shifted
    logic [2:0] line_bot [`LM_PIXEL_WIDTH];
    logic [2:0] cap_top [HALF][`LM_PLANES][`LM_PIXEL_WIDTH];
    logic [2:0] cap_bot [HALF][`LM_PLANES][`LM_PIXEL_WIDTH];
    row_t trk_row;
    plane_t trk_plane;
    plane_t lit_plane;
    int pix_cnt;
    int on_cycles;
    bit on_pending;
    int frame_cnt;
    integer seed;

    led_matrix_top dut0 (
        .clk_root(clk_root),
        .rst_n(rst_n),
        .serial_in(serial_in),
        .panel(panel)
    );

    initial begin
        clk_root = 1'b0;
        forever #4 clk_root = ~clk_root;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED t=%0t %s got=%b expected=%b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_row(input row_t got, input row_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED t=%0t panel.row got=%0d expected=%0d",
                                        $time, got, exp));
        end
    endtask

    task automatic check_on_time(input int got, input int exp);
        if (got != exp) begin
            stop_with_failure($sformatf(
                "CHECK FAILED t=%0t oe_n low cycles got=%0d expected=%0d",
                $time, got, exp));
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED t=%0t %s got=%b expected=%b",
                                        $time, name, got, exp));
        end
    endtask

    // expected bits for one pixel on one plane, bit 0 red, 1 green, 2 blue
    function automatic logic [2:0] expect_rgb(input rgb565_t px, input plane_t p,
                                              input display_ctrl_t c);
        logic [5:0] r6;
        logic [5:0] b6;
        logic [2:0] bits;
        r6 = (6'(px.r) << 1) | 6'(px.r >> 4); // msb repeated below the lsb
        b6 = (6'(px.b) << 1) | 6'(px.b >> 4);
        bits = {b6[p], px.g[p], r6[p]};
        if (!c.brightness_enable[p]) bits = 3'b000;
        return bits & c.rgb_enable;
    endfunction

    task automatic send_byte(input logic [7:0] value, input logic stop_bit);
        logic [9:0] frame;
        int idle_bits;
        frame = {stop_bit, value, 1'b0};
        idle_bits = stop_bit ? 1 : 3; // extra idle so the receiver resyncs
        for (int i = 0; i < 10 + idle_bits; i++) begin
            @(posedge clk_root);
            #1 serial_in = (i < 10) ? frame[i] : 1'b1;
            repeat (`LM_CLKS_PER_BIT - 1) @(posedge clk_root);
        end
    endtask

    task automatic write_pixel(input int x, input int y, input logic [15:0] value);
        send_byte(CMD_PIXEL, 1'b1);
        send_byte(8'(x), 1'b1);
        send_byte(8'(y), 1'b1);
        send_byte(value[15:8], 1'b1);
        send_byte(value[7:0], 1'b1);
        model_fb[y][x] = value;
    endtask

    task automatic fill_random();
        for (int y = 0; y < `LM_PIXEL_HEIGHT; y++) begin
            for (int x = 0; x < `LM_PIXEL_WIDTH; x++) begin
                write_pixel(x, y, 16'($random(seed)));
            end
        end
    endtask

    task automatic check_frame();
        int start;
        int cycles;
        start = frame_cnt;
        cycles = 0;
        // the first frame may have begun before the last write
        while (frame_cnt < start + 2) begin
            @(posedge clk_root);
            cycles++;
            if (cycles > FRAME_TIMEOUT) stop_with_failure("timeout: the scan completed no frame");
        end
        for (int r = 0; r < HALF; r++) begin
            for (int p = 0; p < `LM_PLANES; p++) begin
                for (int c = 0; c < `LM_PIXEL_WIDTH; c++) begin
                    check_rgb($sformatf("rgb1 row %0d plane %0d col %0d", r, p, c),
                              cap_top[r][p][c],
                              expect_rgb(model_fb[r][c], plane_t'(p), model_ctrl));
                    check_rgb($sformatf("rgb2 row %0d plane %0d col %0d", r, p, c),
                              cap_bot[r][p][c],
                              expect_rgb(model_fb[r + HALF][c], plane_t'(p), model_ctrl));
                end
            end
        end
    endtask

    task automatic check_idle_panel();
        check_strobe("panel.clk_pixel", panel.clk_pixel, 1'b0);
        check_strobe("panel.latch", panel.latch, 1'b0);
        check_strobe("panel.oe_n", panel.oe_n, 1'b1);
    endtask

    // panel monitor, tracks row and plane by counting latches
    always @(negedge clk_root) begin
        if (rst_n) begin
            if (!panel.oe_n) on_cycles++;
            if (panel.clk_pixel) begin
                if (on_pending) begin
                    check_on_time(on_cycles, `LM_ON_BASE << lit_plane);
                    on_pending = 1'b0;
                end
                if (pix_cnt < `LM_PIXEL_WIDTH) begin
                    line_top[pix_cnt] = panel.rgb1;
                    line_bot[pix_cnt] = panel.rgb2;
                end
                pix_cnt++;
            end
            if (panel.latch) begin
                if (pix_cnt != `LM_PIXEL_WIDTH) begin
                    stop_with_failure($sformatf("latch came after %0d pixel clocks, not %0d",
                                                pix_cnt, `LM_PIXEL_WIDTH));
                end
                check_row(panel.row, trk_row);
                for (int c = 0; c < `LM_PIXEL_WIDTH; c++) begin
                    cap_top[trk_row][trk_plane][c] = line_top[c];
                    cap_bot[trk_row][trk_plane][c] = line_bot[c];
                end
                lit_plane = trk_plane;
                on_cycles = 0;
                on_pending = 1'b1;
                pix_cnt = 0;
                if (trk_plane == plane_t'(`LM_PLANES - 1)) begin
                    trk_plane = '0;
                    if (trk_row == row_t'(HALF - 1)) frame_cnt++; // last row, frame done
                    trk_row = trk_row + 1'b1;
                end else begin
                    trk_plane = trk_plane + 1'b1;
                end
            end
        end
    end

    initial begin
        integer fd;
        integer code;
        logic [7:0] kind;
        int fld [5];
        logic [8*128-1:0] text;
        bit done;
        rst_n = 1'b0;
        serial_in = 1'b1;
        seed = 36755;
        model_ctrl = '1;
        trk_row = '0;
        trk_plane = '0;
        lit_plane = '0;
        pix_cnt = 0;
        on_cycles = 0;
        on_pending = 1'b0;
        frame_cnt = 0;
        done = 1'b0;
        fd = $fopen("test/led_patterns.txt", "r");
        if (fd == 0) stop_with_failure("cannot open test/led_patterns.txt");
        repeat (10) begin
            @(negedge clk_root);
            check_idle_panel();
        end
        @(posedge clk_root);
        #1 rst_n = 1'b1;
        @(negedge clk_root);
        check_idle_panel(); // scan idle right out of reset
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (kind)
                    "#": code = $fgets(text, fd);
                    "P": begin
                        code = $fscanf(fd, "%d %d %h", fld[0], fld[1], fld[2]);
                        write_pixel(fld[0], fld[1], fld[2][15:0]);
                    end
                    "C": begin
                        code = $fscanf(fd, "%h", fld[0]);
                        send_byte(CMD_COLOUR, 1'b1);
                        send_byte(fld[0][7:0], 1'b1);
                        model_ctrl.rgb_enable = fld[0][2:0];
                    end
                    "M": begin
                        code = $fscanf(fd, "%h", fld[0]);
                        send_byte(CMD_MASK, 1'b1);
                        send_byte(fld[0][7:0], 1'b1);
                        model_ctrl.brightness_enable = fld[0][`LM_PLANES-1:0];
                    end
                    "R": fill_random();
                    "F": check_frame();
                    "S": begin
                        code = $fscanf(fd, "%d %d %d %d %d",
                                       fld[0], fld[1], fld[2], fld[3], fld[4]);
                        check_rgb($sformatf("spot rgb1 row %0d plane %0d col %0d",
                                            fld[0], fld[1], fld[2]),
                                  cap_top[fld[0]][fld[1]][fld[2]], fld[3][2:0]);
                        check_rgb($sformatf("spot rgb2 row %0d plane %0d col %0d",
                                            fld[0], fld[1], fld[2]),
                                  cap_bot[fld[0]][fld[1]][fld[2]], fld[4][2:0]);
                    end
                    "B": begin
                        // framing error byte, then a byte that only counts if it was taken
                        code = $fscanf(fd, "%h %h", fld[0], fld[1]);
                        send_byte(fld[0][7:0], 1'b0);
                        send_byte(fld[1][7:0], 1'b1);
                    end
                    default: stop_with_failure($sformatf("unknown line kind %c in pattern file",
                                                         kind));
                endcase
            end
        end
        $fclose(fd);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
